// File: logic/uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// System clock and default line rate
`define UART_CLK_FREQ_HZ 125000000
`define UART_BAUD_RATE   115200

// Receiver samples per bit period
`define UART_OVERSAMPLE 16

// Cycles per bit at the default rate, kept inside 1..65535
`define UART_DEFAULT_DIV_RAW (`UART_CLK_FREQ_HZ / `UART_BAUD_RATE)
`define UART_DEFAULT_DIV ((`UART_DEFAULT_DIV_RAW < 1) ? 1 : \
    ((`UART_DEFAULT_DIV_RAW > 65535) ? 65535 : `UART_DEFAULT_DIV_RAW))

// Transmit queue entries, power of two
`define UART_TX_FIFO_DEPTH 8

`endif

// File: logic/uart_pkg.sv
package uart_pkg;

    // Runtime configuration of the core
    typedef struct packed {
        logic [15:0] baud_divisor;  // Cycles per bit, 0 selects default
        logic        cts_gate_en;   // 0 ignores uart_cts_n
    } uart_cfg_t;

    // One received byte with its qualifiers
    typedef struct packed {
        logic [7:0] data;
        logic       valid;          // Good frame pulse
        logic       frame_err;      // Stop bit was low
    } uart_rx_result_t;

    // Status levels seen from the bus side
    typedef struct packed {
        logic       tx_busy;
        logic       fifo_full;
        logic       fifo_empty;
        logic [3:0] fifo_count;
    } uart_status_t;

endpackage

// File: logic/uart_tx_fifo.sv
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_tx_fifo (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,       // Empties the queue in one cycle
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       take,        // Pop strobe from the transmitter
    output logic [7:0] head_data,
    output logic       head_avail,
    output logic       full,
    output logic [3:0] count
);

    localparam int DEPTH = `UART_TX_FIFO_DEPTH;
    localparam int AW = $clog2(DEPTH);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [3:0]    count_q;
    logic          do_push;
    logic          do_pop;

    // Full queue drops the push, empty queue ignores take
    assign do_push = push && !full && !flush;
    assign do_pop = take && head_avail;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at DEPTH
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, push and pop together leave it unchanged
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            count_q <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 4'd1;
                2'b01:   count_q <= count_q - 4'd1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign head_data = mem[rd_ptr];
    assign head_avail = (count_q != 4'd0);
    assign full = (count_q == 4'(DEPTH));
    assign count = count_q;

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_tx import uart_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       soft_reset,
    input  uart_cfg_t  cfg,
    input  logic [7:0] head_data,
    input  logic       head_avail,
    input  logic       uart_cts_n,      // Active low clear to send
    output logic       take,
    output logic       uart_txd,
    output logic       tx_busy,
    output logic       tx_done
);

    localparam logic [15:0] DEFAULT_DIV = 16'(`UART_DEFAULT_DIV);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } tx_state_t;

    tx_state_t   state;
    logic [15:0] div_q;         // Divisor of the frame in flight
    logic [15:0] baud_cnt;
    logic        baud_tick;
    logic [2:0]  bit_cnt;
    logic [7:0]  shift_q;
    logic        cts_ok;
    logic        done_q;

    assign cts_ok = !cfg.cts_gate_en || !uart_cts_n;

    // Leave idle with the head byte
    assign take = (state == ST_IDLE) && head_avail && cts_ok && !soft_reset;

    // Divisor may only change between frames
    always_ff @(posedge clk) begin
        if (rst) begin
            div_q <= DEFAULT_DIV;
        end else if (state == ST_IDLE) begin
            div_q <= (cfg.baud_divisor != 16'd0) ? cfg.baud_divisor : DEFAULT_DIV;
        end
    end

    // One tick at the last cycle of every bit period
    assign baud_tick = (state != ST_IDLE) && (baud_cnt == div_q - 16'd1);

    always_ff @(posedge clk) begin
        if (rst || soft_reset || state == ST_IDLE || baud_tick) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || soft_reset) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    bit_cnt <= '0;
                    if (take) begin
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    if (baud_tick && cts_ok) begin  // Else another start period
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (baud_tick) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= ST_STOP;
                        end
                    end
                end
                ST_STOP: begin
                    if (baud_tick) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Data shifts out LSB first
    always_ff @(posedge clk) begin
        if (take) begin
            shift_q <= head_data;
        end else if (state == ST_DATA && baud_tick) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || soft_reset) begin
            done_q <= 1'b0;
        end else begin
            done_q <= (state == ST_STOP) && baud_tick;
        end
    end

    always_comb begin
        case (state)
            ST_START: uart_txd = 1'b0;
            ST_DATA:  uart_txd = shift_q[0];
            default:  uart_txd = 1'b1;  // Idle and stop
        endcase
    end

    assign tx_busy = (state != ST_IDLE);
    assign tx_done = done_q;

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        tx_done |-> !tx_busy && uart_txd ##1 !tx_done);
    a_idle_high: assert property (@(posedge clk) disable iff (rst)
        !tx_busy && !take |=> uart_txd);
    a_take_from_idle: assert property (@(posedge clk) disable iff (rst)
        take |-> !tx_busy ##1 (tx_busy && !uart_txd));

endmodule

// File: logic/uart_rx.sv
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_rx import uart_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            soft_reset,
    input  uart_cfg_t       cfg,
    input  logic            uart_rxd,
    output uart_rx_result_t rx
);

    localparam logic [15:0] DEFAULT_DIV = 16'(`UART_DEFAULT_DIV);
    localparam int OVERSAMPLE = `UART_OVERSAMPLE;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } rx_state_t;

    rx_state_t   state;
    logic        rxd_meta;
    logic        rxd_s;
    logic        rxd_d;         // Previous synchronized level for edge detect
    logic [15:0] div_q;
    logic [15:0] tick_limit;
    logic [15:0] tick_cnt;
    logic        tick;
    logic [3:0]  samp_cnt;      // Ticks within the current bit
    logic [2:0]  bit_cnt;
    logic [7:0]  shift_q;
    logic        valid_q;
    logic        err_q;

    // Two flops against metastability, line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_s    <= 1'b1;
            rxd_d    <= 1'b1;
        end else begin
            rxd_meta <= uart_rxd;
            rxd_s    <= rxd_meta;
            rxd_d    <= rxd_s;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            div_q <= DEFAULT_DIV;
        end else if (state == ST_IDLE) begin
            div_q <= (cfg.baud_divisor != 16'd0) ? cfg.baud_divisor : DEFAULT_DIV;
        end
    end

    // Sample tick every div/OVERSAMPLE cycles
    assign tick_limit = (div_q >= 16'(OVERSAMPLE)) ? (div_q / 16'(OVERSAMPLE)) - 16'd1 : 16'd0;
    assign tick = (state != ST_IDLE) && (tick_cnt == tick_limit);

    always_ff @(posedge clk) begin
        if (rst || soft_reset || state == ST_IDLE || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || soft_reset) begin
            state    <= ST_IDLE;
            samp_cnt <= '0;
            bit_cnt  <= '0;
            valid_q  <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            err_q   <= 1'b0;
            case (state)
                ST_IDLE: begin
                    samp_cnt <= '0;
                    bit_cnt  <= '0;
                    if (rxd_d && !rxd_s) begin  // Falling edge
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    if (tick) begin
                        samp_cnt <= samp_cnt + 4'd1;
                        if (samp_cnt == 4'd7) begin
                            samp_cnt <= '0;
                            state    <= rxd_s ? ST_IDLE : ST_DATA;  // Glitch goes back
                        end
                    end
                end
                ST_DATA: begin
                    if (tick) begin
                        samp_cnt <= samp_cnt + 4'd1;   // Wraps after 16 ticks
                        if (samp_cnt == 4'd15) begin
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7) begin
                                state <= ST_STOP;
                            end
                        end
                    end
                end
                ST_STOP: begin
                    if (tick) begin
                        samp_cnt <= samp_cnt + 4'd1;
                        if (samp_cnt == 4'd15) begin
                            valid_q <= rxd_s;
                            err_q   <= !rxd_s;
                            state   <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == ST_DATA && tick && samp_cnt == 4'd15) begin
            shift_q <= {rxd_s, shift_q[7:1]};
        end
    end

    assign rx = '{data: shift_q, valid: valid_q, frame_err: err_q};

    a_one_result: assert property (@(posedge clk) disable iff (rst)
        (rx.valid || rx.frame_err) |-> !(rx.valid && rx.frame_err)
            ##1 !(rx.valid || rx.frame_err));
    a_div_min: assert property (@(posedge clk) disable iff (rst)
        (state != ST_IDLE) |-> div_q >= 16'(OVERSAMPLE));

endmodule

// File: logic/uart_core.sv
`timescale 1ns/1ps

module uart_core import uart_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  uart_cfg_t       cfg,
    input  logic            soft_reset,
    input  logic [7:0]      wr_data,
    input  logic            wr_en,
    input  logic            uart_cts_n,
    input  logic            uart_rxd,
    output logic            uart_txd,
    output uart_status_t    status,
    output uart_rx_result_t rx,
    output logic            tx_done
);

    logic [7:0] head_data;
    logic       head_avail;
    logic       take;
    logic       fifo_full;
    logic [3:0] fifo_count;
    logic       tx_busy;

    uart_tx_fifo fifo0 (
        .clk        (clk),
        .rst        (rst),
        .flush      (soft_reset),
        .push       (wr_en),
        .push_data  (wr_data),
        .take       (take),
        .head_data  (head_data),
        .head_avail (head_avail),
        .full       (fifo_full),
        .count      (fifo_count)
    );

    uart_tx tx0 (
        .clk        (clk),
        .rst        (rst),
        .soft_reset (soft_reset),
        .cfg        (cfg),
        .head_data  (head_data),
        .head_avail (head_avail),
        .uart_cts_n (uart_cts_n),
        .take       (take),
        .uart_txd   (uart_txd),
        .tx_busy    (tx_busy),
        .tx_done    (tx_done)
    );

    uart_rx rx0 (
        .clk        (clk),
        .rst        (rst),
        .soft_reset (soft_reset),
        .cfg        (cfg),
        .uart_rxd   (uart_rxd),
        .rx         (rx)
    );

    // Empty is simply the inverse of the availability level
    assign status = '{tx_busy: tx_busy, fifo_full: fifo_full,
                      fifo_empty: !head_avail, fifo_count: fifo_count};

endmodule

// File: bench/uart_core_tb.sv
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_core_tb import uart_pkg::*; ();

    localparam int DIV = 32;                // Cycles per bit in every test
    localparam int CLK_NS = 20;
    localparam int DEPTH = `UART_TX_FIFO_DEPTH;
    localparam int FRAME_TOTAL = 16 + 4 + 2 + 1 + 1 + DEPTH;
    localparam int WATCHDOG_NS = (FRAME_TOTAL + 20) * 10 * DIV * CLK_NS;

    logic            clk;
    logic            rst;
    uart_cfg_t       cfg;
    logic            soft_reset;
    logic [7:0]      wr_data;
    logic            wr_en;
    logic            uart_cts_n;
    logic            uart_txd;
    logic            uart_rxd;
    logic            loop_en;       // 0 hands the rx line to drv_rxd
    logic            drv_rxd;
    uart_status_t    status;
    uart_rx_result_t rx;
    logic            tx_done;

    logic [7:0] rx_expect[$];        // Bytes still owed on rx.valid
    logic [7:0] tx_expect[$];        // Bytes still owed on uart_txd
    int         seed = 84;
    int         err_count = 0;
    int         test_err_start;
    int         pass_count = 0;
    int         fail_count = 0;
    int         rx_valid_count = 0;
    int         frame_err_count = 0;
    int         frames_checked = 0;
    string      cur_test = "init";

    assign uart_rxd = loop_en ? uart_txd : drv_rxd;

    uart_core dut0 (
        .clk(clk), .rst(rst), .cfg(cfg), .soft_reset(soft_reset),
        .wr_data(wr_data), .wr_en(wr_en), .uart_cts_n(uart_cts_n),
        .uart_rxd(uart_rxd), .uart_txd(uart_txd), .status(status),
        .rx(rx), .tx_done(tx_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Run timed out before all tests finished (%s)", cur_test);
        $display(">>> FAIL");
        $finish;
    end

    task automatic check_value(input string what, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (expected === actual) else begin
            $display("CHECK FAILED %s %s: expected %0h actual %0h",
                     cur_test, what, expected, actual);
            err_count++;
        end
    endtask

    a_soft_reset_idle: assert property (@(posedge clk) disable iff (rst)
        soft_reset |=> (uart_txd && !status.tx_busy && status.fifo_empty)) else begin
        $display("%s: transmitter or FIFO not idle after soft reset", cur_test);
        err_count++;
    end
    a_cts_blocks_take: assert property (@(posedge clk) disable iff (rst)
        (cfg.cts_gate_en && uart_cts_n) |-> !dut0.take) else begin
        $display("%s: a byte was taken while CTS was deasserted", cur_test);
        err_count++;
    end
    a_one_result: assert property (@(posedge clk) disable iff (rst)
        !(rx.valid && rx.frame_err)) else begin
        $display("%s: valid and frame error pulsed together", cur_test);
        err_count++;
    end

    // Checks each frame on the line against the bytes accepted by the FIFO
    initial begin : frame_monitor
        logic [7:0] exp_byte;
        logic       started;
        logic       aborted;
        int         idx;
        forever begin
            @(posedge clk);
            started = !rst && dut0.take;
            while (started) begin
                exp_byte = 8'h00;
                if (tx_expect.size() == 0) begin
                    $display("%s: transmitter took a byte that was never accepted", cur_test);
                    err_count++;
                end else begin
                    exp_byte = tx_expect.pop_front();
                end
                aborted = 1'b0;
                idx = 0;
                while (!aborted && idx < 10 * DIV) begin
                    @(posedge clk);
                    if (rst || soft_reset) begin
                        aborted = 1'b1;
                    end else begin
                        if (idx < DIV) check_value("start bit", 16'd0, uart_txd);
                        else if (idx < 9 * DIV)
                            check_value("data bit", exp_byte[(idx - DIV) / DIV], uart_txd);
                        else check_value("stop bit", 16'd1, uart_txd);
                        check_value("tx_done in frame", 16'd0, tx_done);
                        idx++;
                    end
                end
                @(posedge clk);     // First idle cycle where the next take may come
                if (!aborted) begin
                    check_value("tx_done", 16'd1, tx_done);
                    frames_checked++;
                end
                started = !aborted && !rst && dut0.take;
            end
        end
    end

    initial begin : rx_monitor
        logic [7:0] exp_byte;
        forever begin
            @(posedge clk);
            if (!rst && rx.valid) begin
                rx_valid_count++;
                if (rx_expect.size() == 0) begin
                    $display("%s: received byte %0h that was never sent", cur_test, rx.data);
                    err_count++;
                end else begin
                    exp_byte = rx_expect.pop_front();
                    check_value("rx data", exp_byte, rx.data);
                end
            end
            if (!rst && rx.frame_err) frame_err_count++;
        end
    end

    task automatic begin_test(input string name);
        cur_test = name;
        test_err_start = err_count;
    endtask

    task automatic end_test();
        if (err_count == test_err_start) begin
            pass_count++;
            $display("Test %s: passed", cur_test);
        end else begin
            fail_count++;
            $display("Test %s: failed with %0d errors", cur_test, err_count - test_err_start);
        end
    endtask

    // Runs on a falling edge and records the byte unless the FIFO is full
    task automatic push_byte(input logic [7:0] b);
        if (!status.fifo_full) begin
            rx_expect.push_back(b);
            tx_expect.push_back(b);
        end
        wr_data = b;
        wr_en = 1'b1;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic wait_rx_count(input int target, input int frames);
        int n;
        n = 0;
        while (rx_valid_count < target && n < frames * 12 * DIV + 100) begin
            @(negedge clk);
            n++;
        end
        if (rx_valid_count < target) begin
            $display("%s: timed out with %0d of %0d bytes received",
                     cur_test, rx_valid_count, target);
            err_count++;
        end
    endtask

    task automatic wait_tx_idle();
        int n;
        n = 0;
        while ((status.tx_busy || !status.fifo_empty) && n < 20 * 12 * DIV) begin
            @(negedge clk);
            n++;
        end
        if (status.tx_busy || !status.fifo_empty) begin
            $display("%s: timed out waiting for the transmitter to go idle", cur_test);
            err_count++;
        end
        repeat (3) @(negedge clk);
    endtask

    task automatic drive_raw_frame(input logic [7:0] b, input logic stop_bit);
        logic [9:0] bits;
        int         i;
        bits = {stop_bit, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            drv_rxd = bits[i];
            repeat (DIV) @(negedge clk);
        end
        drv_rxd = 1'b1;
    endtask

    initial begin : main
        int start_rx;
        int start_err;
        int start_frames;
        int i;
        logic [7:0] patterns [4];
        rst = 1'b1;
        cfg = '{baud_divisor: 16'(DIV), cts_gate_en: 1'b1};
        soft_reset = 1'b0;
        wr_data = 8'h00;
        wr_en = 1'b0;
        uart_cts_n = 1'b0;
        loop_en = 1'b1;
        drv_rxd = 1'b1;
        patterns = '{8'h00, 8'hff, 8'h55, 8'ha3};
        repeat (5) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);

        begin_test("loopback");
        start_rx = rx_valid_count;
        for (i = 0; i < 16; i++) begin
            while (status.fifo_full) @(negedge clk);
            push_byte(8'($random(seed)));
        end
        wait_rx_count(start_rx + 16, 16);
        check_value("bytes left", 16'd0, 16'(rx_expect.size()));
        wait_tx_idle();
        end_test();

        begin_test("frame_shape");
        start_frames = frames_checked;
        for (i = 0; i < 4; i++) push_byte(patterns[i]);
        wait_rx_count(rx_valid_count + 4, 4);
        wait_tx_idle();
        check_value("frames", 16'd4, 16'(frames_checked - start_frames));
        end_test();

        begin_test("cts_hold");
        uart_cts_n = 1'b1;
        start_rx = rx_valid_count;
        push_byte(8'h3c);
        repeat (5 * DIV) begin
            @(negedge clk);
            check_value("txd held", 16'd1, uart_txd);
            check_value("fifo_empty held", 16'd0, status.fifo_empty);
        end
        uart_cts_n = 1'b0;
        wait_rx_count(start_rx + 1, 1);
        wait_tx_idle();
        cfg.cts_gate_en = 1'b0;         // CTS ignored from here
        uart_cts_n = 1'b1;
        push_byte(8'hc5);
        wait_rx_count(start_rx + 2, 1);
        wait_tx_idle();
        uart_cts_n = 1'b0;
        cfg.cts_gate_en = 1'b1;
        end_test();

        begin_test("soft_reset");
        start_rx = rx_valid_count;
        push_byte(8'hc3);
        push_byte(8'h5a);               // Waits in the FIFO behind the aborted byte
        i = 0;
        while (!status.tx_busy && i < 20) begin
            @(negedge clk);
            i++;
        end
        check_value("busy before abort", 16'd1, status.tx_busy);
        check_value("fifo_empty before abort", 16'd0, status.fifo_empty);
        repeat (3 * DIV) @(negedge clk);    // Well into the data bits
        soft_reset = 1'b1;
        @(negedge clk);
        soft_reset = 1'b0;
        rx_expect.delete();
        tx_expect.delete();
        check_value("txd", 16'd1, uart_txd);
        check_value("tx_busy", 16'd0, status.tx_busy);
        check_value("fifo_empty", 16'd1, status.fifo_empty);
        repeat (12 * DIV) @(negedge clk);
        check_value("rx after abort", 16'(start_rx), 16'(rx_valid_count));
        end_test();

        begin_test("framing_error");
        start_rx = rx_valid_count;
        start_err = frame_err_count;
        loop_en = 1'b0;
        drive_raw_frame(8'h96, 1'b0);
        i = 0;
        while (frame_err_count == start_err && i < 12 * DIV) begin
            @(negedge clk);
            i++;
        end
        repeat (2 * DIV) @(negedge clk);
        check_value("frame_err pulses", 16'd1, 16'(frame_err_count - start_err));
        check_value("valid pulses", 16'd0, 16'(rx_valid_count - start_rx));
        loop_en = 1'b1;
        end_test();

        begin_test("fifo_full");
        start_rx = rx_valid_count;
        uart_cts_n = 1'b1;
        for (i = 0; i < DEPTH + 2; i++) push_byte(8'($random(seed)));
        check_value("fifo_count", 16'(DEPTH), status.fifo_count);
        check_value("fifo_full", 16'd1, status.fifo_full);
        check_value("accepted", 16'(DEPTH), 16'(rx_expect.size()));
        uart_cts_n = 1'b0;
        wait_rx_count(start_rx + DEPTH, DEPTH);
        repeat (12 * DIV) @(negedge clk);
        check_value("received", 16'(DEPTH), 16'(rx_valid_count - start_rx));
        end_test();

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+logic
logic/uart_pkg.sv
logic/uart_tx_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_core.sv
bench/uart_core_tb.sv
